// ==== logic/rv_pkg.sv ====
package rv_pkg;

  // datapath widths
  localparam int xlen = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  // program counter stepping
  localparam word_t pc_step = 32'd4;
  localparam word_t reset_pc = 32'd0;

  // major opcodes kept by this core
  localparam opcode_t op_reg_imm = 7'b0010011;
  localparam opcode_t op_reg_reg = 7'b0110011;
  localparam opcode_t op_lui = 7'b0110111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_jal = 7'b1101111;
  localparam opcode_t op_jalr = 7'b1100111;
  localparam opcode_t op_store = 7'b0100011;
  localparam opcode_t op_system = 7'b1110011;

  // funct3 for register-register and register-immediate ops
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_sr = 3'b101;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // only word stores are supported
  localparam logic [2:0] f3_sw = 3'b010;

  // funct7 marking sub and sra
  localparam logic [6:0] f7_alt = 7'b0100000;

  // alu operations, pass_b is used for lui
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

endpackage

// ==== logic/insn_decode.sv ====
`timescale 1ns/100ps

module insn_decode (
  input  rv_pkg::word_t    insn,
  input  logic             rst,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output logic             reg_we,
  output rv_pkg::word_t    imm,
  output logic             use_imm,
  output rv_pkg::alu_op_t  alu_op,
  output logic             wb_link,
  output logic             is_branch,
  output logic [2:0]       branch_f3,
  output logic             is_jal,
  output logic             is_jalr,
  output logic             store_en,
  output logic             halt
);

  rv_pkg::opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_pkg::word_t imm_i, imm_s, imm_b, imm_j, imm_u;
  logic reg_we_dec, store_en_dec, halt_dec;

  // shared mapping for reg-reg and reg-imm arithmetic
  function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_t op;
    case (f3)
      rv_pkg::f3_add:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:  op = rv_pkg::alu_sll;
      rv_pkg::f3_slt:  op = rv_pkg::alu_slt;
      rv_pkg::f3_sltu: op = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:  op = rv_pkg::alu_xor;
      rv_pkg::f3_sr:   op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:   op = rv_pkg::alu_or;
      default:         op = rv_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign {funct7, rs2, rs1, funct3, rd, opcode} = insn;
  assign branch_f3 = funct3;

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    reg_we_dec = 1'b0;
    store_en_dec = 1'b0;
    halt_dec = 1'b0;
    imm = '0;
    use_imm = 1'b0;
    alu_op = rv_pkg::alu_add;
    wb_link = 1'b0;
    is_branch = 1'b0;
    is_jal = 1'b0;
    is_jalr = 1'b0;
    case (opcode)
      rv_pkg::op_reg_imm: begin
        imm = imm_i;
        use_imm = 1'b1;
        alu_op = arith_op(funct3, funct3 == rv_pkg::f3_sr && funct7 == rv_pkg::f7_alt);
        // shifts carry funct7 in the upper immediate bits
        if (funct3 == rv_pkg::f3_sll)
          reg_we_dec = (funct7 == 7'b0);
        else if (funct3 == rv_pkg::f3_sr)
          reg_we_dec = (funct7 == 7'b0) || (funct7 == rv_pkg::f7_alt);
        else
          reg_we_dec = 1'b1;
      end
      rv_pkg::op_reg_reg: begin
        alu_op = arith_op(funct3, funct7 == rv_pkg::f7_alt);
        reg_we_dec = (funct7 == 7'b0) || (funct7 == rv_pkg::f7_alt &&
                     (funct3 == rv_pkg::f3_add || funct3 == rv_pkg::f3_sr));
      end
      rv_pkg::op_lui: begin
        imm = imm_u;
        use_imm = 1'b1;
        alu_op = rv_pkg::alu_pass_b;
        reg_we_dec = 1'b1;
      end
      rv_pkg::op_branch: begin
        imm = imm_b;
        // funct3 010 and 011 are not branches
        is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      rv_pkg::op_jal: begin
        imm = imm_j;
        is_jal = 1'b1;
        wb_link = 1'b1;
        reg_we_dec = 1'b1;
      end
      rv_pkg::op_jalr: begin
        imm = imm_i;
        is_jalr = (funct3 == 3'b000);
        wb_link = 1'b1;
        reg_we_dec = (funct3 == 3'b000);
      end
      rv_pkg::op_store: begin
        imm = imm_s;
        use_imm = 1'b1;
        store_en_dec = (funct3 == rv_pkg::f3_sw);
      end
      rv_pkg::op_system: begin
        // ecall only, every other field zero
        halt_dec = (insn[31:7] == 25'b0);
      end
      default: begin
      end
    endcase
  end

  // nothing leaves the core while reset is held
  assign reg_we = reg_we_dec & ~rst;
  assign store_en = store_en_dec & ~rst;
  assign halt = halt_dec & ~rst;

  // a store must never also write a register
  always_comb begin
    assert #0 (!(store_en && reg_we))
      else $error("store and register write in the same instruction");
  end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  logic             we,
  input  rv_pkg::word_t    rd_data,
  input  rv_pkg::word_t    link_data,
  input  logic             wb_link,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [rv_pkg::num_regs];
  rv_pkg::word_t wr_data;

  // jumps write the return address instead of the alu result
  assign wr_data = wb_link ? link_data : rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++)
        regs[i] <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= wr_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  x0_stays_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
    else $error("x0 was written");

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::word_t   imm,
  input  logic            use_imm,
  output rv_pkg::word_t   result
);

  rv_pkg::word_t opb;
  logic [4:0] shamt;

  // second operand is either rs2 or the immediate
  assign opb = use_imm ? imm : b;

  // shifts use only the low five bits
  assign shamt = opb[4:0];

  always_comb begin
    case (op)
      rv_pkg::alu_add: begin
        result = a + opb;
      end
      rv_pkg::alu_sub: begin
        result = a - opb;
      end
      rv_pkg::alu_sll: begin
        result = a << shamt;
      end
      rv_pkg::alu_slt: begin
        result = {31'b0, $signed(a) < $signed(opb)};
      end
      rv_pkg::alu_sltu: begin
        result = {31'b0, a < opb};
      end
      rv_pkg::alu_xor: begin
        result = a ^ opb;
      end
      rv_pkg::alu_srl: begin
        result = a >> shamt;
      end
      rv_pkg::alu_sra: begin
        // arithmetic shift keeps the sign bit
        result = $unsigned($signed(a) >>> shamt);
      end
      rv_pkg::alu_or: begin
        result = a | opb;
      end
      rv_pkg::alu_and: begin
        result = a & opb;
      end
      rv_pkg::alu_pass_b: begin
        result = opb;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// ==== logic/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  input  logic          is_branch,
  input  logic          is_jal,
  input  logic          is_jalr,
  input  logic [2:0]    branch_f3,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t link_addr
);

  logic taken;
  rv_pkg::word_t jalr_target;
  rv_pkg::word_t next_pc;

  // branch condition, signedness follows funct3
  always_comb begin
    case (branch_f3)
      rv_pkg::f3_beq:  taken = (rs1_data == rs2_data);
      rv_pkg::f3_bne:  taken = (rs1_data != rs2_data);
      rv_pkg::f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::f3_bltu: taken = (rs1_data < rs2_data);
      rv_pkg::f3_bgeu: taken = (rs1_data >= rs2_data);
      default:         taken = 1'b0;
    endcase
  end

  assign link_addr = pc + rv_pkg::pc_step;
  assign jalr_target = (rs1_data + imm) & ~rv_pkg::word_t'(1);

  always_comb begin
    if (is_jalr)
      next_pc = jalr_target;
    else if (is_jal || (is_branch && taken))
      next_pc = pc + imm;
    else
      next_pc = link_addr;
  end

  always_ff @(posedge clk) begin
    if (rst)
      pc <= rv_pkg::reset_pc;
    else
      pc <= next_pc;
  end

  // a misaligned target from jalr or a bad offset shows up here
  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t insn,
  output rv_pkg::word_t pc,
  output logic          halt,
  output rv_pkg::word_t store_addr,
  output rv_pkg::word_t store_data,
  output logic          store_en
);

  // decode outputs
  rv_pkg::reg_idx_t rs1, rs2, rd;
  logic reg_we;
  rv_pkg::word_t imm;
  logic use_imm;
  rv_pkg::alu_op_t alu_op;
  logic wb_link;
  logic is_branch, is_jal, is_jalr;
  logic [2:0] branch_f3;

  // datapath values
  rv_pkg::word_t rs1_data, rs2_data;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t link_addr;

  insn_decode u_decode (
    .insn      (insn),
    .rst       (rst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .reg_we    (reg_we),
    .imm       (imm),
    .use_imm   (use_imm),
    .alu_op    (alu_op),
    .wb_link   (wb_link),
    .is_branch (is_branch),
    .branch_f3 (branch_f3),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .store_en  (store_en),
    .halt      (halt)
  );

  reg_file u_regs (
    .clk       (clk),
    .rst       (rst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .we        (reg_we),
    .rd_data   (alu_result),
    .link_data (link_addr),
    .wb_link   (wb_link),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  alu u_alu (
    .op      (alu_op),
    .a       (rs1_data),
    .b       (rs2_data),
    .imm     (imm),
    .use_imm (use_imm),
    .result  (alu_result)
  );

  branch_unit u_branch (
    .clk       (clk),
    .rst       (rst),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .branch_f3 (branch_f3),
    .pc        (pc),
    .link_addr (link_addr)
  );

  // store address comes from the alu, data straight from rs2
  assign store_addr = alu_result;
  assign store_data = rs2_data;

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int half_period = 5;
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // power-on reset, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== test/tb_imem.sv ====
`timescale 1ns/100ps

module tb_imem (
  input  rv_pkg::word_t pc,
  output rv_pkg::word_t insn
);

  localparam int depth = 64;
  localparam int idx_bits = 6;
  localparam rv_pkg::word_t ecall_insn = {25'b0, rv_pkg::op_system};

  rv_pkg::word_t mem [depth];

  // past the end the core sees ecall and stops
  assign insn = (pc < depth * 4) ? mem[pc[idx_bits+1:2]] : ecall_insn;

  // filler is an addi to x0 that holds the byte address
  task automatic clear_all();
    for (int i = 0; i < depth; i++)
      mem[i] = {12'(i * 4), 5'd0, 3'b000, 5'd0, rv_pkg::op_reg_imm};
  endtask

  task automatic write_word(input int idx, input rv_pkg::word_t value);
    mem[idx] = value;
  endtask

  initial begin
    clear_all();
  end

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core;

  localparam int num_tests = 6;
  localparam int max_prog_len = 64;
  localparam int reset_cycles = 16;
  // twice the longest programs plus power-on reset
  localparam int max_cycles = (num_tests * max_prog_len + reset_cycles) * 2;
  localparam rv_pkg::word_t ecall_insn = {25'b0, rv_pkg::op_system};
  localparam rv_pkg::word_t stray_addr = 32'h3f0;

  // op codes 0..9 are add sub sll slt sltu xor srl sra or and
  localparam logic [9:0][2:0] code_f3 = {
    rv_pkg::f3_and, rv_pkg::f3_or, rv_pkg::f3_sr, rv_pkg::f3_sr, rv_pkg::f3_xor,
    rv_pkg::f3_sltu, rv_pkg::f3_slt, rv_pkg::f3_sll, rv_pkg::f3_add, rv_pkg::f3_add};
  // reg-imm cases as op code and raw immediate with case 0 rightmost
  localparam logic [9:0][3:0] ri_code = {
    4'd7, 4'd6, 4'd2, 4'd9, 4'd8, 4'd5, 4'd4, 4'd3, 4'd0, 4'd0};
  localparam logic [9:0][11:0] ri_imm = {
    12'd9, 12'd9, 12'd7, 12'hff0, 12'h0f0, 12'hfff, 12'hfff, 12'hfff, 12'd1000, 12'hed4};
  localparam logic [5:0][2:0] br_f3 = {
    rv_pkg::f3_bgeu, rv_pkg::f3_bltu, rv_pkg::f3_bge, rv_pkg::f3_blt, rv_pkg::f3_bne,
    rv_pkg::f3_beq};

  logic clk;
  logic por_rst;
  logic test_rst;
  logic rst;
  logic halt;
  logic store_en;
  rv_pkg::word_t insn, pc, store_addr, store_data;

  int cycle_count = 0;
  int checks = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int prog_idx;
  rv_pkg::word_t lcg_state;
  rv_pkg::word_t halt_pc;
  rv_pkg::word_t got_addr[$], got_data[$], exp_addr[$], exp_data[$];

  assign rst = por_rst | test_rst;

  tb_clock u_clock (.clk(clk), .rst(por_rst));

  tb_imem u_imem (.pc(pc), .insn(insn));

  rv_core DUT (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .pc         (pc),
    .halt       (halt),
    .store_addr (store_addr),
    .store_data (store_data),
    .store_en   (store_en)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout after %0d cycles, a program never reached ecall", cycle_count);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input rv_pkg::word_t got,
      input rv_pkg::word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("at %0t: %s", $time, what);
    end
  endtask

  function automatic rv_pkg::word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
      input rv_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg_reg};
  endfunction

  function automatic rv_pkg::word_t i_type(input rv_pkg::opcode_t op, input logic [11:0] imm,
      input rv_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t s_type(input logic [11:0] off, input rv_pkg::reg_idx_t src,
      input rv_pkg::reg_idx_t base);
    return {off[11:5], src, base, rv_pkg::f3_sw, off[4:0], rv_pkg::op_store};
  endfunction

  function automatic rv_pkg::word_t b_type(input logic [2:0] f3, input rv_pkg::reg_idx_t rs1,
      input rv_pkg::reg_idx_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
  endfunction

  function automatic rv_pkg::word_t j_type(input rv_pkg::reg_idx_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
  endfunction

  function automatic rv_pkg::word_t u_type(input rv_pkg::reg_idx_t rd, input logic [19:0] upper);
    return {upper, rd, rv_pkg::op_lui};
  endfunction

  // reference results from the ISA rules
  function automatic rv_pkg::word_t model_alu(input int code, input rv_pkg::word_t a,
      input rv_pkg::word_t b);
    int sh;
    sh = b[4:0];
    case (code)
      0: return a + b;
      1: return a - b;
      2: return a << sh;
      // differing signs decide a signed compare on their own
      3: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      4: return {31'b0, a < b};
      5: return a ^ b;
      6: return a >> sh;
      7: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      8: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t a,
      input rv_pkg::word_t b);
    logic lt_s;
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);
    case (f3)
      rv_pkg::f3_beq:  return a == b;
      rv_pkg::f3_bne:  return a != b;
      rv_pkg::f3_blt:  return lt_s;
      rv_pkg::f3_bge:  return !lt_s;
      rv_pkg::f3_bltu: return a < b;
      default:         return !(a < b);
    endcase
  endfunction

  task automatic emit(input rv_pkg::word_t w);
    u_imem.write_word(prog_idx, w);
    prog_idx++;
  endtask

  task automatic load_const(input rv_pkg::reg_idx_t rd, input rv_pkg::word_t value);
    rv_pkg::word_t upper;
    // addi sign-extends its immediate so the upper part is rounded
    upper = value + 32'h800;
    emit(u_type(rd, upper[31:12]));
    emit(i_type(rv_pkg::op_reg_imm, value[11:0], rd, rv_pkg::f3_add, rd));
  endtask

  // stray stores that show up if a jump lands short
  task automatic pad_to(input int idx);
    while (prog_idx < idx)
      emit(s_type(stray_addr[11:0], 5'd0, 5'd0));
  endtask

  task automatic expect_store(input rv_pkg::word_t addr, input rv_pkg::word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic begin_program();
    @(posedge clk);
    test_rst <= 1'b1;
    u_imem.clear_all();
    prog_idx = 0;
    got_addr.delete();
    got_data.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic run_program();
    logic done;
    done = 1'b0;
    repeat (2) @(posedge clk);
    test_rst <= 1'b0;
    // sample mid-cycle once outputs settle for the presented instruction
    while (!done) begin
      @(negedge clk);
      if (halt) begin
        done = 1'b1;
        halt_pc = pc;
        check_cond(!store_en, "a store was issued in the ecall cycle");
      end else if (store_en) begin
        got_addr.push_back(store_addr);
        got_data.push_back(store_data);
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    int n;
    n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
    check_cond(got_addr.size() == exp_addr.size(),
               $sformatf("expected %0d stores but saw %0d", exp_addr.size(), got_addr.size()));
    for (int k = 0; k < n; k++) begin
      check_word("store_addr", got_addr[k], exp_addr[k]);
      check_word("store_data", got_data[k], exp_data[k]);
    end
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    begin_program();
    // an ecall at pc 0 must not halt while reset is held
    emit(ecall_insn);
    @(posedge clk);
    @(negedge clk);
    check_word("pc", pc, 32'h0);
    check_word("halt", {31'b0, halt}, 32'h0);
    // x5 is never written
    prog_idx = 0;
    emit(s_type(12'h040, 5'd5, 5'd0));
    emit(ecall_insn);
    @(negedge clk);
    check_word("pc", pc, 32'h0);
    check_word("store_en", {31'b0, store_en}, 32'h0);
    expect_store(32'h040, 32'h0);
    run_program();
    finish_test("reset", e0);
  endtask

  task automatic test_reg_reg();
    rv_pkg::word_t a, b;
    int e0;
    e0 = errors;
    // negative a and positive b split slt from sltu
    a = lcg_next() | 32'h8000_0000;
    b = lcg_next() & 32'h7fff_ffff;
    begin_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int code = 0; code < 10; code++) begin
      emit(r_type((code == 1 || code == 7) ? rv_pkg::f7_alt : 7'b0, 5'd2, 5'd1,
                  code_f3[code], 5'd3));
      emit(s_type(12'h100 + 12'(4 * code), 5'd3, 5'd0));
      expect_store(32'h100 + 4 * code, model_alu(code, a, b));
    end
    emit(ecall_insn);
    run_program();
    finish_test("reg_reg", e0);
  endtask

  task automatic test_reg_imm();
    rv_pkg::word_t a;
    logic [11:0] field;
    int code;
    int e0;
    e0 = errors;
    a = lcg_next() | 32'h8000_0000;
    begin_program();
    load_const(5'd1, a);
    for (int k = 0; k < 10; k++) begin
      code = ri_code[k];
      field = (code == 7) ? {rv_pkg::f7_alt, ri_imm[k][4:0]} : ri_imm[k];
      emit(i_type(rv_pkg::op_reg_imm, field, 5'd1, code_f3[code], 5'd3));
      emit(s_type(12'h100 + 12'(4 * k), 5'd3, 5'd0));
      expect_store(32'h100 + 4 * k, model_alu(code, a, {{20{field[11]}}, field}));
    end
    emit(u_type(5'd4, 20'habcde));
    emit(s_type(12'h180, 5'd4, 5'd0));
    expect_store(32'h180, 32'habcde000);
    // writes to x0 are dropped
    emit(i_type(rv_pkg::op_reg_imm, 12'd123, 5'd1, rv_pkg::f3_add, 5'd0));
    emit(u_type(5'd0, 20'h12345));
    emit(s_type(12'h184, 5'd0, 5'd0));
    expect_store(32'h184, 32'h0);
    emit(ecall_insn);
    run_program();
    finish_test("reg_imm", e0);
  endtask

  task automatic test_branches();
    rv_pkg::word_t base, va, vb;
    rv_pkg::reg_idx_t ra, rb;
    logic [2:0] f3;
    int e0;
    e0 = errors;
    begin_program();
    // x1 holds -1 and x2 holds 1 with markers in x3 and x4
    emit(i_type(rv_pkg::op_reg_imm, 12'hfff, 5'd0, rv_pkg::f3_add, 5'd1));
    emit(i_type(rv_pkg::op_reg_imm, 12'd1, 5'd0, rv_pkg::f3_add, 5'd2));
    emit(i_type(rv_pkg::op_reg_imm, 12'h111, 5'd0, rv_pkg::f3_add, 5'd3));
    emit(i_type(rv_pkg::op_reg_imm, 12'h222, 5'd0, rv_pkg::f3_add, 5'd4));
    for (int j = 0; j < 12; j++) begin
      f3 = br_f3[j / 2];
      ra = (j % 2 == 0 || f3 == rv_pkg::f3_beq || f3 == rv_pkg::f3_bne) ? 5'd1 : 5'd2;
      rb = (j % 2 == 0) ? 5'd2 : 5'd1;
      va = (ra == 5'd1) ? 32'hffff_ffff : 32'd1;
      vb = (rb == 5'd1) ? 32'hffff_ffff : 32'd1;
      base = 32'h200 + 8 * j;
      emit(b_type(f3, ra, rb, 13'd8));
      emit(s_type(base[11:0], 5'd3, 5'd0));
      emit(s_type(base[11:0] + 12'd4, 5'd4, 5'd0));
      if (!branch_taken(f3, va, vb))
        expect_store(base, 32'h111);
      expect_store(base + 4, 32'h222);
    end
    emit(ecall_insn);
    run_program();
    finish_test("branches", e0);
  endtask

  task automatic test_jumps();
    rv_pkg::word_t jump_pc;
    int e0;
    e0 = errors;
    begin_program();
    jump_pc = prog_idx * 4;
    emit(j_type(5'd1, 21'd12));
    pad_to((jump_pc + 12) / 4);
    emit(s_type(12'h300, 5'd1, 5'd0));
    expect_store(32'h300, jump_pc + 4);
    // odd jalr target loses bit 0
    emit(i_type(rv_pkg::op_reg_imm, 12'd33, 5'd0, rv_pkg::f3_add, 5'd5));
    jump_pc = prog_idx * 4;
    emit(i_type(rv_pkg::op_jalr, 12'd0, 5'd5, 3'b000, 5'd6));
    pad_to(((33 + 0) & ~1) / 4);
    emit(s_type(12'h304, 5'd6, 5'd0));
    expect_store(32'h304, jump_pc + 4);
    emit(i_type(rv_pkg::op_reg_imm, 12'd60, 5'd0, rv_pkg::f3_add, 5'd5));
    jump_pc = prog_idx * 4;
    emit(i_type(rv_pkg::op_jalr, 12'd5, 5'd5, 3'b000, 5'd7));
    pad_to(((60 + 5) & ~1) / 4);
    emit(s_type(12'h308, 5'd7, 5'd0));
    expect_store(32'h308, jump_pc + 4);
    jump_pc = prog_idx * 4;
    emit(j_type(5'd8, 21'd8));
    pad_to((jump_pc + 8) / 4);
    emit(s_type(12'h30c, 5'd8, 5'd0));
    expect_store(32'h30c, jump_pc + 4);
    emit(ecall_insn);
    run_program();
    finish_test("jumps", e0);
  endtask

  task automatic test_ecall();
    rv_pkg::word_t ecall_pc;
    int e0;
    e0 = errors;
    begin_program();
    emit(i_type(rv_pkg::op_reg_imm, 12'd7, 5'd0, rv_pkg::f3_add, 5'd3));
    emit(s_type(12'h400, 5'd3, 5'd0));
    expect_store(32'h400, 32'd7);
    ecall_pc = prog_idx * 4;
    emit(ecall_insn);
    run_program();
    check_word("pc", halt_pc, ecall_pc);
    finish_test("ecall", e0);
  endtask

  initial begin
    test_rst = 1'b0;
    lcg_state = 32'd42;
    while (por_rst !== 1'b0)
      @(posedge clk);
    test_reset();
    test_reg_reg();
    test_reg_imm();
    test_branches();
    test_jumps();
    test_ecall();
    $display("%0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== build.f ====
logic/rv_pkg.sv
logic/insn_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/branch_unit.sv
logic/rv_core.sv
test/tb_clock.sv
test/tb_imem.sv
test/tb_rv_core.sv
